// ==== dv/calib_hist_sva.sv ====
// bound assertions on the loop outputs: strobe width, trim timing, lock and window spacing
module calib_hist_sva import calib_const_pkg::*, calib_ctrl_pkg::*; #(
    parameter int NWIN = NWIN_DEF
) (
    input logic       clk,
    input logic       rstb,
    input logic       en,
    input logic       meas_done,
    input hist_cmp_t  hist_comp,
    input trim_code_t trim,
    input logic       locked
);

    timeunit 1ns;
    timeprecision 1ps;

    int   gap;
    logic run_seen;

    // cycles since the last strobe, and a strobe seen with en held high
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            gap      <= 0;
            run_seen <= 1'b0;
        end else begin
            gap <= meas_done ? 1 : gap + 1;
            if (!en) begin
                run_seen <= 1'b0;
            end else if (meas_done) begin
                run_seen <= 1'b1;
            end
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rstb)
        meas_done |=> !meas_done)
        else $error("meas_done high in two consecutive cycles");

    a_trim_timing: assert property (@(posedge clk) disable iff (!rstb)
        !$stable(trim) |-> $past(meas_done))
        else $error("trim changed without a preceding meas_done");

    // the strobe cycle of a skewed window still shows the old state
    a_lock_balanced: assert property (@(posedge clk) disable iff (!rstb)
        (locked && !meas_done) |-> (hist_comp == CMP_HOLD))
        else $error("locked while hist_comp is nonzero");

    a_done_spacing: assert property (@(posedge clk) disable iff (!rstb)
        (meas_done && run_seen) |-> (gap == (1 << NWIN)))
        else $error("meas_done spacing differs from the window length");

endmodule

bind calib_hist_top calib_hist_sva #(
    .NWIN      (NWIN)
) u_sva (
    .clk       (clk),
    .rstb      (rstb),
    .en        (en),
    .meas_done (meas_done),
    .hist_comp (hist_comp),
    .trim      (trim),
    .locked    (locked)
);

// ==== dv/calib_hist_tb.sv ====
// testbench for the calibration loop: stimulus, reference model, checks and watchdog
module calib_hist_tb import calib_const_pkg::*, calib_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NWIN    = NWIN_DEF;
    localparam int NLOCK   = NLOCK_DEF;
    localparam int WIN     = 1 << NWIN;
    localparam int CLK_PER = 8;
    localparam int TRIM_HI = (1 << (TRIM_W - 1)) - 1;
    localparam int TRIM_LO = -(1 << (TRIM_W - 1));

    // windows per phase
    localparam int N_RAND  = 24;
    localparam int N_SAT   = 70;
    localparam int N_LOCK  = NLOCK + 2;
    localparam int N_REEN  = 4;
    localparam int N_OFF   = 100;
    localparam int N_TOTAL = N_RAND + 2 * N_SAT + N_LOCK + 1 + N_REEN;
    localparam int WATCHDOG_NS = ((N_TOTAL + 4) * WIN + N_OFF) * CLK_PER;

    // stimulus modes
    localparam int M_RAND   = 0;
    localparam int M_EMPTY  = 1;
    localparam int M_CENTER = 2;
    localparam int M_SPREAD = 3;

    logic       clk;
    logic       rstb;
    logic       en;
    adc_code_t  din;
    range_t     nbin;
    range_t     dz;
    hist_cnt_t  hist_center;
    hist_cnt_t  hist_side;
    hist_cmp_t  hist_comp;
    logic       meas_done;
    trim_code_t trim;
    logic       locked;

    integer seed = 99916;
    string  test_name = "reset";
    int     fail_cnt = 0;
    int     since_en = 0;
    int     since_done = 0;
    bit     first_pending = 1'b1;
    int     trim_held;

    // reference model state
    int           m_cnt = 0;
    int           m_sum = 0;
    int           m_avg = 0;
    int           m_center = 0;
    int           m_left = 0;
    int           m_right = 0;
    int           m_exp_center = 0;
    int           m_exp_side = 0;
    int           m_exp_comp = 0;
    bit           m_done = 1'b0;
    int           m_trim = 0;
    int           m_run = 0;
    calib_state_t m_state = st_idle;

    calib_hist_top dut0 (
        .clk         (clk),
        .rstb        (rstb),
        .en          (en),
        .din         (din),
        .nbin        (nbin),
        .dz          (dz),
        .hist_center (hist_center),
        .hist_side   (hist_side),
        .hist_comp   (hist_comp),
        .meas_done   (meas_done),
        .trim        (trim),
        .locked      (locked)
    );

    always #(CLK_PER / 2) clk = ~clk;

    function automatic int cmp_rule(input int center, input int side, input int dzv);
        int diff;
        int band;
        diff = center - side;
        band = 1 << dzv;
        if (center == 0 && side == 0) return 1;
        if (diff > band) return -1;
        if (diff < -band) return 1;
        return 0;
    endfunction

    // integrator and lock counter act on the previous cycle's strobe
    task automatic trim_step();
        int sum;
        if (m_state != st_idle && m_done) begin
            sum = m_trim + m_exp_comp;
            m_trim = (sum > TRIM_HI) ? TRIM_HI : ((sum < TRIM_LO) ? TRIM_LO : sum);
        end
        if (m_state == st_idle) begin
            if (en) begin
                m_state = st_track;
                m_run = 0;
            end
        end else if (!en) begin
            m_state = st_idle;
            m_run = 0;
        end else if (m_done) begin
            if (m_exp_comp != 0) begin
                m_state = st_track;
                m_run = 0;
            end else if (m_state == st_track) begin
                m_run = m_run + 1;
                if (m_run == NLOCK) m_state = st_locked;
            end
        end
    endtask

    // bins keep counting while disabled, only the window end clears them
    task automatic window_step();
        int d;
        int t;
        int nb;
        int side;
        d = int'(din);
        nb = int'(nbin) + 1;
        if (en && m_cnt == WIN - 1) begin
            side = (m_left + m_right) >> 1;
            m_exp_center = m_center;
            m_exp_side = side;
            m_exp_comp = cmp_rule(m_center, side, int'(dz));
            m_done = 1'b1;
            m_center = 0;
            m_left = 0;
            m_right = 0;
            m_avg = (m_sum + d) >>> NWIN;
            m_sum = 0;
            m_cnt = 0;
        end else begin
            t = d - m_avg;
            if (t > -nb && t < nb) m_center = m_center + 1;
            else if (t > -3 * nb && t <= -nb) m_left = m_left + 1;
            else if (t >= nb && t < 3 * nb) m_right = m_right + 1;
            m_cnt = en ? m_cnt + 1 : 0;
            m_sum = en ? m_sum + d : 0;
        end
    endtask

    always @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            m_cnt = 0;
            m_sum = 0;
            m_avg = 0;
            m_center = 0;
            m_left = 0;
            m_right = 0;
            m_exp_center = 0;
            m_exp_side = 0;
            m_exp_comp = 0;
            m_done = 1'b0;
            m_trim = 0;
            m_run = 0;
            m_state = st_idle;
        end else begin
            trim_step();
            m_done = 1'b0;
            window_step();
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            fail_cnt = fail_cnt + 1;
            $display("FAIL %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch in %s", what);
        end
    endtask

    task automatic compare_outputs();
        since_en = since_en + 1;
        since_done = since_done + 1;
        check_value("meas_done", m_done, meas_done);
        check_value("hist_center", m_exp_center, hist_center);
        check_value("hist_side", m_exp_side, hist_side);
        check_value("hist_comp", m_exp_comp, int'(hist_comp));
        check_value("trim", m_trim, int'(trim));
        check_value("locked", m_state == st_locked, locked);
        if (meas_done) begin
            if (first_pending) check_value("first_done_gap", WIN, since_en);
            else check_value("done_spacing", WIN, since_done);
            first_pending = 1'b0;
            since_done = 0;
        end
    endtask

    task automatic drive(input int mode, input int phase);
        case (mode)
            M_RAND: begin
                if (phase == 0) begin
                    nbin = range_t'({$random(seed)} % 8);
                    dz = range_t'({$random(seed)} % 6);
                end
                din = adc_code_t'($random(seed) % 61);
            end
            M_EMPTY: din = (phase % 2 == 0) ? adc_code_t'(60) : adc_code_t'(-60);
            M_CENTER: din = '0;
            default: begin
                // two center samples, one left, one right
                case (phase % 4)
                    2: din = adc_code_t'(-1);
                    3: din = adc_code_t'(1);
                    default: din = '0;
                endcase
            end
        endcase
    endtask

    task automatic start_enable();
        en = 1'b1;
        since_en = 0;
        first_pending = 1'b1;
    endtask

    task automatic run_windows(input string name, input int mode, input int count);
        int seen;
        int phase;
        test_name = name;
        seen = 0;
        phase = 0;
        if (mode != M_RAND) begin
            nbin = '0;
            dz = range_t'(5);
        end
        drive(mode, phase);
        while (seen < count) begin
            @(negedge clk);
            compare_outputs();
            phase = phase + 1;
            if (meas_done) begin
                seen = seen + 1;
                phase = 0;
            end
            if (seen < count) drive(mode, phase);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, meas_done stopped before all windows finished");
        $display("STATUS: FAIL");
        $fatal(1, "simulation timeout");
    end

    initial begin
        clk = 1'b0;
        rstb = 1'b0;
        en = 1'b0;
        din = '0;
        nbin = '0;
        dz = '0;
        repeat (3) @(negedge clk);
        rstb = 1'b1;
        repeat (4) begin
            @(negedge clk);
            compare_outputs();
        end
        start_enable();
        run_windows("random_bins", M_RAND, N_RAND);
        run_windows("empty_trim_up", M_EMPTY, N_SAT);
        check_value("empty_center", 0, hist_center);
        check_value("empty_side", 0, hist_side);
        check_value("empty_comp", 1, int'(hist_comp));
        check_value("trim_max", TRIM_HI, int'(trim));
        run_windows("center_trim_down", M_CENTER, N_SAT);
        check_value("trim_min", TRIM_LO, int'(trim));
        run_windows("lock", M_SPREAD, N_LOCK);
        check_value("lock_reached", 1, locked);
        run_windows("unlock", M_CENTER, 1);
        @(negedge clk);
        compare_outputs();
        check_value("lock_cleared", 0, locked);
        test_name = "disable";
        trim_held = int'(trim);
        en = 1'b0;
        repeat (N_OFF) begin
            drive(M_RAND, 1);
            @(negedge clk);
            compare_outputs();
            check_value("done_while_off", 0, meas_done);
        end
        check_value("trim_held", trim_held, int'(trim));
        start_enable();
        run_windows("reenable", M_RAND, N_REEN);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/calib_const_pkg.sv
rtl/calib_ctrl_pkg.sv
rtl/hist_meas_if.sv
rtl/calib_avg_track.sv
rtl/calib_hist_measure.sv
rtl/calib_trim_update.sv
rtl/calib_hist_top.sv
dv/calib_hist_sva.sv
dv/calib_hist_tb.sv

// ==== rtl/calib_avg_track.sv ====
// window sequencer and block averager producing the reference average and update pulse
module calib_avg_track import calib_const_pkg::*; #(
    parameter int NWIN = NWIN_DEF
) (
    input  logic      clk,
    input  logic      rstb,
    input  logic      en,
    input  adc_code_t din,
    output adc_code_t din_avg,
    output logic      update
);

    // sum of 2^NWIN codes needs NWIN extra bits
    localparam int ACC_W = ADC_W + NWIN;

    logic [NWIN-1:0]         smp_cnt;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] acc_next;

    // running sum including the current sample
    assign acc_next = acc + din;

    // last sample of the window
    assign update = en && (smp_cnt == '1);

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            smp_cnt <= '0;
            acc     <= '0;
            din_avg <= '0;
        end else if (!en) begin
            // restart the window, keep the last average
            smp_cnt <= '0;
            acc     <= '0;
        end else begin
            // counter wraps to zero after the last sample
            smp_cnt <= smp_cnt + 1'b1;
            if (update) begin
                acc     <= '0;
                // arithmetic shift keeps the sign of the mean
                din_avg <= adc_code_t'(acc_next >>> NWIN);
            end else begin
                acc <= acc_next;
            end
        end
    end

endmodule

// ==== rtl/calib_const_pkg.sv ====
// widths, width-typed vectors and default window and lock settings for the calibration loop
package calib_const_pkg;

    // adc sample width
    localparam int ADC_W = 8;

    // bin half-width and dead-zone exponent field
    localparam int RANGE_W = 4;

    // bin counters are 2^RANGE_W bits wide
    localparam int CNT_W = 2 ** RANGE_W;

    // trim code width, two's complement
    localparam int TRIM_W = 6;

    typedef logic signed [ADC_W-1:0]  adc_code_t;
    typedef logic        [RANGE_W-1:0] range_t;
    typedef logic        [CNT_W-1:0]   hist_cnt_t;
    typedef logic signed [TRIM_W-1:0]  trim_code_t;

    // saturation limits of the trim integrator
    localparam trim_code_t TRIM_MAX = trim_code_t'((2 ** (TRIM_W - 1)) - 1);
    localparam trim_code_t TRIM_MIN = trim_code_t'(-(2 ** (TRIM_W - 1)));

    // 2^6 = 64 samples per window
    localparam int NWIN_DEF = 6;

    // balanced windows in a row before lock
    localparam int NLOCK_DEF = 4;

endpackage

// ==== rtl/calib_ctrl_pkg.sv ====
// comparison-result type with its values and the calibration state enum
package calib_ctrl_pkg;

    // signed result of the center versus side comparison
    typedef logic signed [1:0] hist_cmp_t;

    // center too large, trim goes down
    localparam hist_cmp_t CMP_DEC  = -2'sd1;
    // balanced within the dead zone
    localparam hist_cmp_t CMP_HOLD = 2'sd0;
    // center too small or empty window, trim goes up
    localparam hist_cmp_t CMP_INC  = 2'sd1;

    // loop state
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_track  = 2'd1,
        st_locked = 2'd2
    } calib_state_t;

endpackage

// ==== rtl/calib_hist_measure.sv ====
// three-bin histogram counters, window snapshot and dead-zone comparison
module calib_hist_measure import calib_const_pkg::*, calib_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rstb,
    input  adc_code_t    din,
    input  adc_code_t    din_avg,
    input  logic         update,
    input  range_t       nbin,
    input  range_t       dz,
    hist_meas_if.source  meas
);

    // two guard bits so the thresholds never wrap
    localparam int EXT_W = ADC_W + 2;

    logic signed [EXT_W-1:0] din_x;
    logic signed [EXT_W-1:0] avg_x;
    logic signed [EXT_W-1:0] bin_near;
    logic signed [EXT_W-1:0] bin_far;
    logic signed [EXT_W-1:0] th_l1;
    logic signed [EXT_W-1:0] th_l2;
    logic signed [EXT_W-1:0] th_r1;
    logic signed [EXT_W-1:0] th_r2;

    logic hit_center;
    logic hit_left;
    logic hit_right;

    hist_cnt_t cnt_center;
    hist_cnt_t cnt_left;
    hist_cnt_t cnt_right;

    logic [CNT_W:0]          side_sum;
    hist_cnt_t               side_tot;
    logic signed [CNT_W+1:0] diff;
    logic signed [CNT_W+1:0] dz_hi;
    logic signed [CNT_W+1:0] dz_lo;
    hist_cmp_t               comp_next;

    assign din_x = EXT_W'(din);
    assign avg_x = EXT_W'(din_avg);

    // nbin+1 and 3*nbin+3
    assign bin_near = EXT_W'(nbin) + EXT_W'(1);
    assign bin_far  = (bin_near <<< 1) + bin_near;

    assign th_l1 = avg_x - bin_near;
    assign th_r1 = avg_x + bin_near;
    assign th_l2 = avg_x - bin_far;
    assign th_r2 = avg_x + bin_far;

    // bin membership around the previous window's average
    assign hit_center = (din_x > th_l1) && (din_x < th_r1);
    assign hit_left   = (din_x > th_l2) && (din_x <= th_l1);
    assign hit_right  = (din_x >= th_r1) && (din_x < th_r2);

    // update cycle clears, its sample is dropped
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            cnt_center <= '0;
            cnt_left   <= '0;
            cnt_right  <= '0;
        end else if (update) begin
            cnt_center <= '0;
            cnt_left   <= '0;
            cnt_right  <= '0;
        end else begin
            cnt_center <= cnt_center + hist_cnt_t'(hit_center);
            cnt_left   <= cnt_left + hist_cnt_t'(hit_left);
            cnt_right  <= cnt_right + hist_cnt_t'(hit_right);
        end
    end

    // mean of the two side bins
    assign side_sum = {1'b0, cnt_left} + {1'b0, cnt_right};
    assign side_tot = hist_cnt_t'(side_sum >> 1);

    assign diff  = $signed({2'b00, cnt_center}) - $signed({2'b00, side_tot});
    assign dz_hi = (CNT_W+2)'(1) << dz;
    assign dz_lo = -dz_hi;

    // empty window pushes trim up like a small center
    always_comb begin
        if (cnt_center == '0 && side_tot == '0) begin
            comp_next = CMP_INC;
        end else if (diff > dz_hi) begin
            comp_next = CMP_DEC;
        end else if (diff < dz_lo) begin
            comp_next = CMP_INC;
        end else begin
            comp_next = CMP_HOLD;
        end
    end

    // snapshot at the end of the window
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            meas.meas_done   <= 1'b0;
            meas.hist_center <= '0;
            meas.hist_side   <= '0;
            meas.hist_comp   <= CMP_HOLD;
        end else begin
            meas.meas_done <= update;
            if (update) begin
                meas.hist_center <= cnt_center;
                meas.hist_side   <= side_tot;
                meas.hist_comp   <= comp_next;
            end
        end
    end

endmodule

// ==== rtl/calib_hist_top.sv ====
// top level of the calibration loop: averager, histogram measure and trim update
module calib_hist_top import calib_const_pkg::*, calib_ctrl_pkg::*; #(
    parameter int NWIN  = NWIN_DEF,
    parameter int NLOCK = NLOCK_DEF
) (
    input  logic       clk,
    input  logic       rstb,
    input  logic       en,
    input  adc_code_t  din,
    input  range_t     nbin,
    input  range_t     dz,
    output hist_cnt_t  hist_center,
    output hist_cnt_t  hist_side,
    output hist_cmp_t  hist_comp,
    output logic       meas_done,
    output trim_code_t trim,
    output logic       locked
);

    // reference level and window strobe from the averager
    adc_code_t din_avg;
    logic      update;

    hist_meas_if meas_bus ();

    calib_avg_track #(
        .NWIN    (NWIN)
    ) u_avg_track (
        .clk     (clk),
        .rstb    (rstb),
        .en      (en),
        .din     (din),
        .din_avg (din_avg),
        .update  (update)
    );

    calib_hist_measure u_hist_measure (
        .clk     (clk),
        .rstb    (rstb),
        .din     (din),
        .din_avg (din_avg),
        .update  (update),
        .nbin    (nbin),
        .dz      (dz),
        .meas    (meas_bus.source)
    );

    calib_trim_update #(
        .NLOCK   (NLOCK)
    ) u_trim_update (
        .clk     (clk),
        .rstb    (rstb),
        .en      (en),
        .meas    (meas_bus.sink),
        .trim    (trim),
        .locked  (locked)
    );

    // measurement result also visible at the pins
    assign hist_center = meas_bus.hist_center;
    assign hist_side   = meas_bus.hist_side;
    assign hist_comp   = meas_bus.hist_comp;
    assign meas_done   = meas_bus.meas_done;

endmodule

// ==== rtl/calib_trim_update.sv ====
// calibration state machine with saturating trim integrator and lock detection
module calib_trim_update import calib_const_pkg::*, calib_ctrl_pkg::*; #(
    parameter int NLOCK = NLOCK_DEF
) (
    input  logic       clk,
    input  logic       rstb,
    input  logic       en,
    hist_meas_if.sink  meas,
    output trim_code_t trim,
    output logic       locked
);

    // run counter must hold NLOCK
    localparam int RUN_W = $clog2(NLOCK + 1);

    calib_state_t state;
    calib_state_t state_next;

    logic [RUN_W-1:0]        run_cnt;
    logic [RUN_W-1:0]        run_next;
    logic signed [TRIM_W:0]  trim_sum;
    trim_code_t              trim_next;

    // one guard bit for the saturation check
    assign trim_sum = trim + meas.hist_comp;

    always_comb begin
        if (trim_sum > TRIM_MAX) begin
            trim_next = TRIM_MAX;
        end else if (trim_sum < TRIM_MIN) begin
            trim_next = TRIM_MIN;
        end else begin
            trim_next = trim_code_t'(trim_sum);
        end
    end

    always_comb begin
        state_next = state;
        run_next   = run_cnt;
        case (state)
            st_idle: begin
                if (en) begin
                    state_next = st_track;
                    run_next   = '0;
                end
            end
            st_track, st_locked: begin
                if (!en) begin
                    state_next = st_idle;
                    run_next   = '0;
                end else if (meas.meas_done) begin
                    if (meas.hist_comp != CMP_HOLD) begin
                        // any skewed window breaks the run
                        state_next = st_track;
                        run_next   = '0;
                    end else if (state == st_track) begin
                        if (run_cnt == RUN_W'(NLOCK - 1)) begin
                            state_next = st_locked;
                        end
                        run_next = run_cnt + 1'b1;
                    end
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state   <= st_idle;
            run_cnt <= '0;
            trim    <= '0;
        end else begin
            state   <= state_next;
            run_cnt <= run_next;
            // frozen while idle
            if (state != st_idle && meas.meas_done) begin
                trim <= trim_next;
            end
        end
    end

    assign locked = (state == st_locked);

endmodule

// ==== rtl/hist_meas_if.sv ====
// interface with the per-window histogram result and its source and sink modports
interface hist_meas_if import calib_const_pkg::*, calib_ctrl_pkg::*; ();

    // held totals of the last finished window
    hist_cnt_t hist_center;
    hist_cnt_t hist_side;
    hist_cmp_t hist_comp;

    // one-cycle strobe for a new result
    logic      meas_done;

    modport source (
        output hist_center,
        output hist_side,
        output hist_comp,
        output meas_done
    );

    modport sink (
        input  hist_center,
        input  hist_side,
        input  hist_comp,
        input  meas_done
    );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the calibration loop testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module calib_hist_tb -f flist.f -o calib_hist_sim

# the result is judged from the log
obj_dir/calib_hist_sim 2>&1 | tee "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
